//--- Makefile
# Verilator flow for the memory unit testbench

TOP := tb_mem_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) -o $(TOP)
	out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

//--- rtl/load_store_queue.sv
// Load/store queue, circular buffer with head, execute and tail pointers
`default_nettype none

module load_store_queue (
    input  wire                        clk_i,
    input  wire                        rstn_i,
    input  wire  mem_pkg::mem_instr_t  instr_i,
    input  wire                        flush_i,
    input  wire                        read_next_i,
    input  wire                        rewind_i,
    input  wire                        advance_head_i,
    output mem_pkg::mem_instr_t        next_instr_o,
    output logic                       full_o,
    output logic                       empty_o
);

    typedef logic [mem_pkg::LSQ_PTR_W-1:0] ptr_t;
    typedef logic [mem_pkg::LSQ_PTR_W:0]   cnt_t;

    mem_pkg::mem_instr_t entries_q [mem_pkg::LSQ_DEPTH];

    ptr_t head_q;
    ptr_t exec_q;
    ptr_t tail_q;
    cnt_t count_q;      // Entries between head and tail
    cnt_t count_d;
    cnt_t exec_cnt_q;   // Entries between execute and tail
    cnt_t exec_cnt_d;
    logic do_write;
    logic do_read;

    assign full_o   = (count_q == cnt_t'(mem_pkg::LSQ_DEPTH));
    assign empty_o  = (exec_cnt_q == '0);
    assign do_write = instr_i.valid & ~full_o;
    assign do_read  = read_next_i & ~empty_o & ~rewind_i;   // Rewind wins

    always_comb begin
        count_d = count_q;
        if (do_write) begin
            count_d = count_d + cnt_t'(1);
        end
        if (advance_head_i) begin
            count_d = count_d - cnt_t'(1);
        end
    end

    always_comb begin
        exec_cnt_d = exec_cnt_q;
        if (rewind_i) begin
            exec_cnt_d = count_d;   // Execute pointer back to head
        end else begin
            if (do_write) begin
                exec_cnt_d = exec_cnt_d + cnt_t'(1);
            end
            if (do_read) begin
                exec_cnt_d = exec_cnt_d - cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head_q     <= '0;
            exec_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
            exec_cnt_q <= '0;
        end else if (flush_i) begin
            head_q     <= '0;
            exec_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
            exec_cnt_q <= '0;
        end else begin
            if (do_write) tail_q <= tail_q + ptr_t'(1);
            if (advance_head_i) head_q <= head_q + ptr_t'(1);
            if (rewind_i) begin
                exec_q <= head_q;
            end else if (do_read) begin
                exec_q <= exec_q + ptr_t'(1);
            end
            count_q    <= count_d;
            exec_cnt_q <= exec_cnt_d;
        end
    end

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (do_write) begin
            entries_q[tail_q] <= instr_i;
        end
    end

    always_comb begin
        next_instr_o       = entries_q[exec_q];
        next_instr_o.valid = ~empty_o;
    end

endmodule

`default_nettype wire

//--- rtl/mem_issue_ctrl.sv
// Issue FSM sending one cache request at a time, with held request copy
`default_nettype none

module mem_issue_ctrl (
    input  wire                        clk_i,
    input  wire                        rstn_i,
    input  wire                        flush_i,
    input  wire                        rewind_i,
    input  wire  mem_pkg::mem_instr_t  lsq_instr_i,
    input  wire                        lsq_empty_i,
    input  wire                        dcache_ready_i,
    input  wire                        commit_store_i,
    input  wire                        store_busy_i,
    output logic                       read_next_o,
    output mem_pkg::dcache_req_t       dcache_req_o,
    output mem_pkg::mem_instr_t        issued_o
);

    typedef enum logic [1:0] {
        ResetState,
        ReadHead,
        WaitReady,
        WaitCommit
    } state_e;

    state_e state_q;
    state_e state_d;

    mem_pkg::mem_instr_t held_q;   // Request waiting in WaitReady or WaitCommit
    mem_pkg::mem_instr_t src;

    logic kill;
    logic src_is_store;
    logic can_go;
    logic req_go;

    assign kill         = flush_i | rewind_i;
    assign src_is_store = mem_pkg::is_store(src.op);
    // Stores need commit permission and no other store in flight
    assign can_go       = dcache_ready_i &
                          (~src_is_store | (commit_store_i & ~store_busy_i));

    //////////////////////////////////////////////////
    // Next state and request source
    //////////////////////////////////////////////////

    always_comb begin
        state_d     = state_q;
        src         = lsq_instr_i;
        read_next_o = 1'b0;
        req_go      = 1'b0;
        case (state_q)
            ResetState: begin
                state_d = ReadHead;
            end
            ReadHead: begin
                if (!lsq_empty_i) begin
                    read_next_o = ~kill;       // Entry is either sent or held
                    req_go      = can_go & ~kill;
                    if (!can_go) begin
                        state_d = dcache_ready_i ? WaitCommit : WaitReady;
                    end
                end
            end
            WaitReady, WaitCommit: begin
                src    = held_q;
                req_go = can_go & ~kill;
                if (can_go) begin
                    state_d = ReadHead;
                end else begin
                    state_d = dcache_ready_i ? WaitCommit : WaitReady;
                end
            end
            default: begin
                state_d = ReadHead;
            end
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ResetState;
        end else if (kill) begin
            state_q <= ReadHead;   // Held copy is dropped, queue refetches it
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (read_next_o) begin
            held_q <= lsq_instr_i;
        end
    end

    //////////////////////////////////////////////////
    // Cache request and issued instruction
    //////////////////////////////////////////////////

    always_comb begin
        dcache_req_o = '0;
        if (req_go) begin
            dcache_req_o.valid = 1'b1;
            dcache_req_o.op    = src.op;
            dcache_req_o.size  = src.size;
            dcache_req_o.base  = src.base;
            dcache_req_o.imm   = src.imm;
        end
    end

    assign issued_o = req_go ? src : '0;   // Nothing enters s1 when blocked

endmodule

`default_nettype wire

//--- rtl/mem_pkg.sv
// Memory unit package with widths, opcodes, causes and bus structs
`default_nettype none

package mem_pkg;

    //////////////////////////////////////////////////
    // Widths and sizes
    //////////////////////////////////////////////////

    localparam int XLEN       = 64;
    localparam int VADDR_MSB  = 39;   // Highest valid virtual address bit
    localparam int LSQ_DEPTH  = 8;
    localparam int LSQ_PTR_W  = 3;
    localparam int GL_INDEX_W = 6;    // Graduation list index
    localparam int REG_W      = 5;

    //////////////////////////////////////////////////
    // Opcodes and encodings
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        LD, LW, LWU, LH, LHU, LB, LBU,
        SD, SW, SH, SB
    } mem_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD,
        SIZE_DOUBLE
    } mem_size_e;

    typedef enum logic [2:0] {
        XCPT_NONE,
        XCPT_LD_MISALIGNED,
        XCPT_ST_MISALIGNED,
        XCPT_LD_ACCESS_FAULT,
        XCPT_ST_ACCESS_FAULT
    } xcpt_cause_e;

    //////////////////////////////////////////////////
    // Bus structs
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;
        mem_op_e               op;
        mem_size_e             size;
        logic [GL_INDEX_W-1:0] gl_index;
        logic [REG_W-1:0]      rd;
        logic [XLEN-1:0]       base;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       st_data;   // Store data, sent at s1
    } mem_instr_t;

    typedef struct packed {
        logic            valid;
        mem_op_e         op;
        mem_size_e       size;
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] imm;
    } dcache_req_t;

    typedef struct packed {
        logic            ready;
        logic            valid;
        logic            nack;
        logic            ma_ld;     // Misaligned load
        logic            ma_st;     // Misaligned store
        logic [XLEN-1:0] addr;      // One cycle after request
        logic [XLEN-1:0] data;      // Two cycles after request
    } dcache_resp_t;

    typedef struct packed {
        logic            valid;
        xcpt_cause_e     cause;
        logic [XLEN-1:0] origin;
    } mem_xcpt_t;

    typedef struct packed {
        logic                  valid;
        logic [GL_INDEX_W-1:0] gl_index;
        logic [REG_W-1:0]      rd;
        logic [XLEN-1:0]       result;
        mem_xcpt_t             xcpt;
    } mem_wb_t;

    // Stores need commit permission and stall commit while in flight
    function automatic logic is_store(mem_op_e op);
        return op inside {SD, SW, SH, SB};
    endfunction

endpackage

`default_nettype wire

//--- rtl/mem_resp_pipe.sv
// s1/s2 response pipeline with outcome decision, exception cause and store flag
`default_nettype none

module mem_resp_pipe (
    input  wire                         clk_i,
    input  wire                         rstn_i,
    input  wire                         flush_i,
    input  wire  mem_pkg::mem_instr_t   issued_i,
    input  wire  mem_pkg::dcache_resp_t dcache_resp_i,
    output logic [mem_pkg::XLEN-1:0]    store_data_o,
    output logic                        rewind_o,
    output logic                        advance_head_o,
    output logic                        store_busy_o,
    output mem_pkg::mem_wb_t            wb_o,
    output mem_pkg::mem_xcpt_t          commit_xcpt_o
);

    localparam int HI_W = mem_pkg::XLEN - 1 - mem_pkg::VADDR_MSB;

    logic                      s1_valid_q;
    logic                      s2_valid_q;
    mem_pkg::mem_instr_t       s1_q;
    mem_pkg::mem_instr_t       s2_q;
    logic [mem_pkg::XLEN-1:0]  addr_s2_q;
    logic                      store_q;    // Store between request and completion

    logic                      s2_is_store;
    logic                      range_fault;
    logic                      store_done;
    mem_pkg::mem_xcpt_t        xcpt_s2;

    //////////////////////////////////////////////////
    // Pipeline registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (flush_i || rewind_o) begin
            s1_valid_q <= 1'b0;   // Nack discards both stages
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= issued_i.valid;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_q      <= issued_i;
        s2_q      <= s1_q;
        addr_s2_q <= dcache_resp_i.addr;   // Address comes back at s1
    end

    assign store_data_o = s1_valid_q ? s1_q.st_data : '0;

    //////////////////////////////////////////////////
    // s2 decision
    //////////////////////////////////////////////////

    assign s2_is_store = mem_pkg::is_store(s2_q.op);
    // Upper bits must sign extend the top virtual address bit
    assign range_fault = addr_s2_q[mem_pkg::XLEN-1:mem_pkg::VADDR_MSB+1] !=
                         {HI_W{addr_s2_q[mem_pkg::VADDR_MSB]}};

    always_comb begin
        xcpt_s2 = '0;
        if (dcache_resp_i.ma_st) begin
            xcpt_s2.cause = mem_pkg::XCPT_ST_MISALIGNED;
        end else if (dcache_resp_i.ma_ld) begin
            xcpt_s2.cause = mem_pkg::XCPT_LD_MISALIGNED;
        end else if (range_fault) begin
            xcpt_s2.cause = s2_is_store ? mem_pkg::XCPT_ST_ACCESS_FAULT
                                        : mem_pkg::XCPT_LD_ACCESS_FAULT;
        end
        if (s2_valid_q && xcpt_s2.cause != mem_pkg::XCPT_NONE) begin
            xcpt_s2.valid  = 1'b1;
            xcpt_s2.origin = addr_s2_q;
        end
    end

    // Nack first, then exception or completion both retire the entry
    assign rewind_o       = s2_valid_q & dcache_resp_i.nack;
    assign advance_head_o = s2_valid_q & ~dcache_resp_i.nack;
    assign store_done     = advance_head_o & s2_is_store;

    always_comb begin
        wb_o = '0;
        if (advance_head_o && !s2_is_store) begin
            wb_o.valid    = 1'b1;
            wb_o.gl_index = s2_q.gl_index;
            wb_o.rd       = s2_q.rd;
            wb_o.result   = xcpt_s2.valid ? '0 : dcache_resp_i.data;
            wb_o.xcpt     = xcpt_s2;
        end
    end

    assign commit_xcpt_o = store_done ? xcpt_s2 : '0;   // Store faults go to commit only

    //////////////////////////////////////////////////
    // Store in flight
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            store_q <= 1'b0;
        end else if (flush_i || rewind_o) begin
            store_q <= 1'b0;
        end else if (issued_i.valid && mem_pkg::is_store(issued_i.op)) begin
            store_q <= 1'b1;
        end else if (store_done) begin
            store_q <= 1'b0;
        end
    end

    assign store_busy_o = store_q & ~store_done;   // Drops in the completing s2 cycle

endmodule

`default_nettype wire

//--- rtl/mem_unit.sv
// Memory unit top, joins queue, issue FSM and response pipeline
`default_nettype none

module mem_unit (
    input  wire                         clk_i,
    input  wire                         rstn_i,
    input  wire                         flush_i,          // Kill and flush
    input  wire  mem_pkg::mem_instr_t   instr_i,
    input  wire                         commit_store_i,   // Commit allows the store
    input  wire  mem_pkg::dcache_resp_t dcache_resp_i,
    output mem_pkg::dcache_req_t        dcache_req_o,
    output logic [mem_pkg::XLEN-1:0]    store_data_o,
    output mem_pkg::mem_wb_t            wb_o,
    output mem_pkg::mem_xcpt_t          commit_xcpt_o,
    output logic                        commit_stall_o,
    output logic                        lock_o,
    output logic                        empty_o
);

    mem_pkg::mem_instr_t next_instr;
    mem_pkg::mem_instr_t issued;
    logic                read_next;
    logic                rewind;
    logic                advance_head;
    logic                store_busy;

    load_store_queue u_lsq (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .instr_i        (instr_i),
        .flush_i        (flush_i),
        .read_next_i    (read_next),
        .rewind_i       (rewind),
        .advance_head_i (advance_head),
        .next_instr_o   (next_instr),
        .full_o         (lock_o),
        .empty_o        (empty_o)
    );

    mem_issue_ctrl u_issue (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .rewind_i       (rewind),
        .lsq_instr_i    (next_instr),
        .lsq_empty_i    (empty_o),
        .dcache_ready_i (dcache_resp_i.ready),
        .commit_store_i (commit_store_i),
        .store_busy_i   (store_busy),
        .read_next_o    (read_next),
        .dcache_req_o   (dcache_req_o),
        .issued_o       (issued)
    );

    mem_resp_pipe u_resp (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .issued_i       (issued),
        .dcache_resp_i  (dcache_resp_i),
        .store_data_o   (store_data_o),
        .rewind_o       (rewind),
        .advance_head_o (advance_head),
        .store_busy_o   (store_busy),
        .wb_o           (wb_o),
        .commit_xcpt_o  (commit_xcpt_o)
    );

    assign commit_stall_o = store_busy;

endmodule

`default_nettype wire

//--- sources.f
rtl/mem_pkg.sv
rtl/load_store_queue.sv
rtl/mem_issue_ctrl.sv
rtl/mem_resp_pipe.sv
rtl/mem_unit.sv
test/tb_mem_unit.sv

//--- test/tb_mem_unit.sv
// Testbench for the memory unit with cache model, reference model and checker
`default_nettype none

module tb_mem_unit;

    localparam int TMO = 400;   // Cycles allowed for any wait

    logic                  clk_i;
    logic                  rstn_i;
    logic                  flush_i;
    mem_pkg::mem_instr_t   instr_i;
    logic                  commit_store_i;
    mem_pkg::dcache_resp_t dcache_resp_i;
    mem_pkg::dcache_req_t  dcache_req_o;
    logic [63:0]           store_data_o;
    mem_pkg::mem_wb_t      wb_o;
    mem_pkg::mem_xcpt_t    commit_xcpt_o;
    logic                  commit_stall_o;
    logic                  lock_o;
    logic                  empty_o;

    int errors;
    int checks;
    string test_name;
    logic [31:0] seed;
    logic [31:0] mseed;
    logic [31:0] cseed;
    logic rdy_rand;
    logic nack_rand;
    int   commit_mode;   // 0 low, 1 high, 2 random
    logic [5:0] gl_cnt;

    logic [7:0]  mem_b [256];     // Cache model storage
    logic [63:0] ref_mem [32];    // Reference view of the same memory
    mem_pkg::mem_wb_t   exp_wb_q [$];
    mem_pkg::mem_xcpt_t exp_xc_q [$];

    mem_unit UUT (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .instr_i        (instr_i),
        .commit_store_i (commit_store_i),
        .dcache_resp_i  (dcache_resp_i),
        .dcache_req_o   (dcache_req_o),
        .store_data_o   (store_data_o),
        .wb_o           (wb_o),
        .commit_xcpt_o  (commit_xcpt_o),
        .commit_stall_o (commit_stall_o),
        .lock_o         (lock_o),
        .empty_o        (empty_o)
    );

    always #10 clk_i = ~clk_i;

    //////////////////////////////////////////////////
    // Helpers and reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int size_bytes(input mem_pkg::mem_op_e op);
        case (op)
            mem_pkg::LD, mem_pkg::SD: return 8;
            mem_pkg::LW, mem_pkg::LWU, mem_pkg::SW: return 4;
            mem_pkg::LH, mem_pkg::LHU, mem_pkg::SH: return 2;
            default: return 1;
        endcase
    endfunction

    function automatic logic is_st(input mem_pkg::mem_op_e op);
        return op == mem_pkg::SD || op == mem_pkg::SW || op == mem_pkg::SH || op == mem_pkg::SB;
    endfunction

    // Sign or zero extension of the low bytes of raw
    function automatic logic [63:0] fmt_load(input mem_pkg::mem_op_e op, input logic [63:0] raw);
        case (op)
            mem_pkg::LW:  return {{32{raw[31]}}, raw[31:0]};
            mem_pkg::LWU: return {32'h0, raw[31:0]};
            mem_pkg::LH:  return {{48{raw[15]}}, raw[15:0]};
            mem_pkg::LHU: return {48'h0, raw[15:0]};
            mem_pkg::LB:  return {{56{raw[7]}}, raw[7:0]};
            mem_pkg::LBU: return {56'h0, raw[7:0]};
            default:      return raw;
        endcase
    endfunction

    function automatic logic addr_fault(input logic [63:0] a);
        return a[63:40] != {24{a[39]}};
    endfunction

    // Expected writeback or exception, valid low for a clean store
    function automatic mem_pkg::mem_wb_t ref_outcome(input mem_pkg::mem_instr_t it);
        mem_pkg::mem_wb_t r;
        logic [63:0] a;
        int n;
        logic st;
        r  = '0;
        a  = it.base + it.imm;
        n  = size_bytes(it.op);
        st = is_st(it.op);
        if ((a % 64'(n)) != 0) begin
            r.xcpt.cause = st ? mem_pkg::XCPT_ST_MISALIGNED : mem_pkg::XCPT_LD_MISALIGNED;
        end else if (addr_fault(a)) begin
            r.xcpt.cause = st ? mem_pkg::XCPT_ST_ACCESS_FAULT : mem_pkg::XCPT_LD_ACCESS_FAULT;
        end
        if (r.xcpt.cause != mem_pkg::XCPT_NONE) begin
            r.xcpt.valid  = 1'b1;
            r.xcpt.origin = a;
        end
        r.valid    = !st || r.xcpt.valid;
        r.gl_index = it.gl_index;
        r.rd       = it.rd;
        if (!st && !r.xcpt.valid) begin
            r.result = fmt_load(it.op, ref_mem[a[7:3]] >> (8 * a[2:0]));
        end
        return r;
    endfunction

    task automatic ref_store(input mem_pkg::mem_instr_t it);
        logic [63:0] a;
        logic [63:0] mask;
        a    = it.base + it.imm;
        mask = (size_bytes(it.op) == 8) ? '1 : ((64'd1 << (8 * size_bytes(it.op))) - 64'd1);
        ref_mem[a[7:3]] = (ref_mem[a[7:3]] & ~(mask << (8 * a[2:0]))) |
                          ((it.st_data & mask) << (8 * a[2:0]));
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout in %s while waiting for %s", test_name, what);
    endtask

    //////////////////////////////////////////////////
    // Cache model
    //////////////////////////////////////////////////

    mem_pkg::dcache_req_t req_n;
    logic [63:0] sd_n;
    logic        flush_n;
    logic        s1_v;
    logic        s2_v;
    logic        s2_nack;
    logic        s2_bad;
    mem_pkg::dcache_req_t s1_r;
    mem_pkg::dcache_req_t s2_r;
    logic [63:0] s2_data;

    always @(negedge clk_i) begin
        req_n   = dcache_req_o;
        sd_n    = store_data_o;
        flush_n = flush_i;
    end

    always @(posedge clk_i) begin
        logic [63:0] a;
        logic [63:0] raw;
        logic        kill;
        logic        ma;
        if (!rstn_i) begin
            s2_v = 1'b0;
            s1_v = 1'b0;
            s2_nack = 1'b0;
            dcache_resp_i <= '0;
        end else begin
            mseed = lcg_next(mseed);
            a = s2_r.base + s2_r.imm;
            // Store leaves s2 and writes the array
            if (s2_v && !s2_nack && !s2_bad && is_st(s2_r.op)) begin
                for (int k = 0; k < size_bytes(s2_r.op); k++) begin
                    mem_b[8'(a[7:0] + 8'(k))] = s2_data[8*k +: 8];
                end
            end
            kill    = flush_n || (s2_v && s2_nack);
            s2_v    = s1_v && !kill;
            s2_r    = s1_r;
            s2_data = sd_n;
            s1_v    = req_n.valid && !kill;
            s1_r    = req_n;
            a       = s2_r.base + s2_r.imm;
            ma      = (a % 64'(size_bytes(s2_r.op))) != 0;
            s2_bad  = ma || addr_fault(a);
            s2_nack = s2_v && nack_rand && (mseed[31:29] == 3'd0);
            for (int k = 0; k < 8; k++) begin
                raw[8*k +: 8] = mem_b[8'(a[7:0] + 8'(k))];
            end
            dcache_resp_i.ready <= rdy_rand ? (mseed[15:14] != 2'd0) : 1'b1;
            dcache_resp_i.addr  <= req_n.base + req_n.imm;   // Seen at s1
            dcache_resp_i.valid <= s2_v;
            dcache_resp_i.nack  <= s2_nack;
            dcache_resp_i.ma_ld <= s2_v && ma && !is_st(s2_r.op);
            dcache_resp_i.ma_st <= s2_v && ma && is_st(s2_r.op);
            dcache_resp_i.data  <= fmt_load(s2_r.op, raw);
        end
    end

    always @(posedge clk_i) begin
        cseed = lcg_next(cseed);
        commit_store_i <= (commit_mode == 2) ? cseed[30] : (commit_mode == 1);
    end

    //////////////////////////////////////////////////
    // Checker
    //////////////////////////////////////////////////

    logic prev_st_req;
    logic prev2_st_req;   // Store request two cycles back, now at s2

    always @(negedge clk_i) begin
        mem_pkg::mem_wb_t   ew;
        mem_pkg::mem_xcpt_t ex;
        mem_pkg::mem_size_e es;
        es = mem_pkg::mem_size_e'($clog2(size_bytes(dcache_req_o.op)));
        if (rstn_i) begin
            if (wb_o.valid) begin
                checks++;
                if (exp_wb_q.size() == 0) begin
                    errors++;
                    $display("Unexpected writeback in %s at %0t", test_name, $time);
                end else begin
                    ew = exp_wb_q.pop_front();
                    if (wb_o != ew) begin
                        errors++;
                        $display("** Error %s writeback: expected %h, actual %h",
                                 test_name, ew, wb_o);
                    end
                end
            end
            if (commit_xcpt_o.valid) begin
                checks++;
                if (exp_xc_q.size() == 0) begin
                    errors++;
                    $display("Unexpected store exception in %s at %0t", test_name, $time);
                end else begin
                    ex = exp_xc_q.pop_front();
                    if (commit_xcpt_o != ex) begin
                        errors++;
                        $display("** Error %s store exception: expected %h, actual %h",
                                 test_name, ex, commit_xcpt_o);
                    end
                end
            end
            if (dcache_req_o.valid && !dcache_resp_i.ready) begin
                errors++;
                $display("Request sent while the cache was not ready in %s", test_name);
            end
            if (dcache_req_o.valid && dcache_req_o.size != es) begin
                errors++;
                $display("** Error %s request size: expected %0d, actual %0d",
                         test_name, es, dcache_req_o.size);
            end
            if (dcache_req_o.valid && is_st(dcache_req_o.op) && !commit_store_i) begin
                errors++;
                $display("Store reached the cache without commit in %s", test_name);
            end
            if (prev_st_req && !commit_stall_o) begin
                errors++;
                $display("Commit stall low after a store request in %s", test_name);
            end
            if (prev2_st_req && !dcache_resp_i.nack && commit_stall_o) begin
                errors++;
                $display("Commit stall still high as a store completed in %s", test_name);
            end
        end
        prev2_st_req = prev_st_req;
        prev_st_req  = dcache_req_o.valid && is_st(dcache_req_o.op);
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic push(input mem_pkg::mem_instr_t it);
        int t;
        t = 0;
        @(posedge clk_i);
        instr_i <= it;
        @(negedge clk_i);
        while (lock_o && t < TMO) begin   // Written at the edge after lock is low
            @(negedge clk_i);
            t++;
        end
        if (t >= TMO) report_timeout("queue space");
        @(posedge clk_i);
        instr_i <= '0;
    endtask

    task automatic push_op(input mem_pkg::mem_op_e op, input logic [63:0] addr,
                           input logic [63:0] data, input logic expect_it);
        mem_pkg::mem_instr_t it;
        mem_pkg::mem_wb_t    r;
        seed        = lcg_next(seed);
        it          = '0;
        it.valid    = 1'b1;
        it.op       = op;
        it.size     = mem_pkg::mem_size_e'($clog2(size_bytes(op)));
        it.gl_index = gl_cnt;
        it.rd       = seed[20:16];
        it.imm      = {56'h0, 3'h0, seed[26:22]};
        it.base     = addr - it.imm;
        it.st_data  = data;
        gl_cnt      = gl_cnt + 6'd1;
        if (expect_it) begin
            r = ref_outcome(it);
            if (!is_st(op)) exp_wb_q.push_back(r);
            else if (r.valid) exp_xc_q.push_back(r.xcpt);
            else ref_store(it);
        end
        push(it);
    endtask

    task automatic run_random(input int n, input logic stores, input logic bad);
        mem_pkg::mem_op_e op;
        logic [63:0] a;
        for (int i = 0; i < n; i++) begin
            seed = lcg_next(seed);
            op   = mem_pkg::mem_op_e'(stores ? seed[31:28] % 11 : seed[31:28] % 7);
            a    = {56'h0, seed[7:0]} & ~64'(size_bytes(op) - 1);
            if (bad && seed[9:8] == 2'd0) a = a | 64'd1;        // Misaligned unless byte
            if (bad && seed[9:8] == 2'd1) a = a | 64'hffff_ff00_0000_0000;
            push_op(op, a, {seed, lcg_next(seed)}, 1'b1);
        end
    endtask

    task automatic drain();
        int t;
        int quiet;
        t = 0;
        quiet = 0;
        rdy_rand = 1'b0;
        commit_mode = 1;
        while (quiet < 4 && t < TMO) begin
            @(negedge clk_i);
            t++;
            if (empty_o && !dcache_req_o.valid && !s1_v && !s2_v &&
                exp_wb_q.size() == 0 && exp_xc_q.size() == 0) quiet++;
            else quiet = 0;
        end
        if (t >= TMO) report_timeout("the unit to drain");
    endtask

    initial begin
        int t;
        clk_i = 1'b0;
        rstn_i = 1'b0;
        flush_i = 1'b0;
        instr_i = '0;
        commit_store_i = 1'b0;
        dcache_resp_i = '0;
        errors = 0;
        checks = 0;
        seed = 32'h80004df8;
        mseed = 32'h80004df8;
        cseed = 32'h80004df8;
        rdy_rand = 1'b0;
        nack_rand = 1'b0;
        commit_mode = 1;
        gl_cnt = '0;
        prev_st_req = 1'b0;
        prev2_st_req = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem_b[i] = 8'(i * 37) ^ 8'h5a;   // Pattern over the whole address
            ref_mem[i / 8][8 * (i % 8) +: 8] = 8'(i * 37) ^ 8'h5a;
        end
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        if (dcache_req_o.valid || wb_o.valid || commit_xcpt_o.valid || commit_stall_o ||
            lock_o || !empty_o) begin
            errors++;
            $display("Outputs not idle after reset");
        end

        test_name = "loads";
        run_random(16, 1'b0, 1'b0);
        drain();

        test_name = "stores";
        commit_mode = 2;
        push_op(mem_pkg::SD, 64'h40, 64'h0123_4567_89ab_cdef, 1'b1);
        push_op(mem_pkg::LD, 64'h40, 64'h0, 1'b1);
        run_random(24, 1'b1, 1'b0);
        drain();

        test_name = "backpressure";
        rdy_rand = 1'b1;
        commit_mode = 2;
        run_random(30, 1'b1, 1'b0);
        drain();

        test_name = "nack";
        nack_rand = 1'b1;
        rdy_rand = 1'b1;
        run_random(30, 1'b1, 1'b0);
        drain();
        nack_rand = 1'b0;

        test_name = "exceptions";
        push_op(mem_pkg::LW, 64'h12, 64'h0, 1'b1);
        push_op(mem_pkg::SH, 64'h21, 64'hbeef, 1'b1);
        push_op(mem_pkg::LD, 64'h0000_0100_0000_0008, 64'h0, 1'b1);
        push_op(mem_pkg::SD, 64'hffff_0000_0000_0010, 64'h1111, 1'b1);
        run_random(20, 1'b1, 1'b1);
        drain();

        // Blocked store at the head fills the queue, then flush
        test_name = "lock and flush";
        commit_mode = 0;
        push_op(mem_pkg::SD, 64'h80, 64'hdead_beef, 1'b0);
        for (int i = 0; i < 7; i++) push_op(mem_pkg::LD, 64'h88, 64'h0, 1'b0);
        t = 0;
        while (!lock_o && t < TMO) begin
            @(negedge clk_i);
            t++;
        end
        if (t >= TMO) report_timeout("lock_o");
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        @(negedge clk_i);
        if (!empty_o || commit_stall_o || lock_o) begin
            errors++;
            $display("Unit not empty after flush");
        end
        repeat (10) @(negedge clk_i);
        commit_mode = 1;
        push_op(mem_pkg::LD, 64'h80, 64'h0, 1'b1);
        drain();

        for (int i = 0; i < 256; i++) begin
            if (mem_b[i] != ref_mem[i / 8][8 * (i % 8) +: 8]) begin
                errors++;
                $display("** Error memory byte %0d: expected %h, actual %h",
                         i, ref_mem[i / 8][8 * (i % 8) +: 8], mem_b[i]);
            end
        end

        $display("Errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
